//--- include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Memory depths in 32-bit words
`define IMEM_WORDS 256
`define DMEM_WORDS 256

// Word index widths derived from the depths
`define IMEM_AW $clog2(`IMEM_WORDS)
`define DMEM_AW $clog2(`DMEM_WORDS)

// Top address bits that must all be one to hit the I/O port
`define IO_TAG_BITS 6

`define RESET_PC 32'h0000_0000

`endif

//--- verilog/isa_pkg.sv
package isa_pkg;

	typedef logic [4:0] reg_t;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_SLTI  = 6'h0a,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// R-type function field
	typedef enum logic [5:0] {
		F_SLL  = 6'h00,
		F_SRL  = 6'h02,
		F_JR   = 6'h08,
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_XOR  = 6'h26,
		F_SLT  = 6'h2a
	} funct_e;

	typedef struct packed {
		opcode_e    op;
		reg_t       rs;
		reg_t       rt;
		reg_t       rd;
		logic [4:0] shamt;
		funct_e     funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_e     op;
		reg_t        rs;
		reg_t        rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef struct packed {
		opcode_e     op;
		logic [25:0] target;
	} j_fmt_t;

	// Same 32 bits, three views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_u;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} alu_op_e;

endpackage

//--- verilog/pipe_pkg.sv
package pipe_pkg;

	// Control bundle produced in decode
	typedef struct packed {
		logic              regwrite;
		logic              memtoreg;
		logic              memread;
		logic              memwrite;
		logic              branch;
		logic              branch_ne;
		logic              alusrc;
		logic              regdst;
		logic              jump;
		logic              jump_reg;
		logic              link;
		isa_pkg::alu_op_e  alu_op;
	} ctrl_t;

	typedef enum logic [1:0] {
		FWD_REG,
		FWD_EX,
		FWD_MEM,
		FWD_WB
	} fwd_sel_e;

	typedef struct packed {
		logic [31:0]     pc_next;
		isa_pkg::instr_u instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t          ctrl;
		logic [31:0]    pc_next;
		logic [31:0]    rs_data;
		logic [31:0]    rt_data;
		logic [31:0]    imm;
		logic [31:0]    jtarget;
		logic [4:0]     shamt;
		isa_pkg::reg_t  rt;
		isa_pkg::reg_t  rd;
	} id_ex_t;

	typedef struct packed {
		ctrl_t          ctrl;
		logic [31:0]    branch_target;
		logic           zero;
		logic [31:0]    result;
		logic [31:0]    rt_data;
		isa_pkg::reg_t  dst;
	} ex_mem_t;

	typedef struct packed {
		logic           regwrite;
		logic [31:0]    wdata;
		isa_pkg::reg_t  dst;
	} mem_wb_t;

	// Data bus request, driven from the memory stage
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        read;
		logic        write;
	} dbus_t;

endpackage

//--- verilog/decoder.sv
`timescale 1ns/1ps

module decoder
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  instr_u instr,
	output ctrl_t  ctrl
);

	always_comb begin
		// Anything not matched below stays a no-op
		ctrl = '0;
		ctrl.alu_op = ALU_ADD;
		case (instr.r.op)
			OP_RTYPE: begin
				ctrl.regwrite = 1'b1;
				ctrl.regdst = 1'b1;
				case (instr.r.funct)
					F_ADDU: ctrl.alu_op = ALU_ADD;
					F_SUBU: ctrl.alu_op = ALU_SUB;
					F_AND:  ctrl.alu_op = ALU_AND;
					F_OR:   ctrl.alu_op = ALU_OR;
					F_XOR:  ctrl.alu_op = ALU_XOR;
					F_SLT:  ctrl.alu_op = ALU_SLT;
					F_SLL:  ctrl.alu_op = ALU_SLL;
					F_SRL:  ctrl.alu_op = ALU_SRL;
					F_JR: begin
						ctrl.regwrite = 1'b0;
						ctrl.regdst = 1'b0;
						ctrl.jump = 1'b1;
						ctrl.jump_reg = 1'b1;
					end
					default: begin
						ctrl.regwrite = 1'b0;
						ctrl.regdst = 1'b0;
					end
				endcase
			end
			OP_ADDIU: ctrl = '{regwrite: 1'b1, alusrc: 1'b1, alu_op: ALU_ADD, default: '0};
			OP_SLTI:  ctrl = '{regwrite: 1'b1, alusrc: 1'b1, alu_op: ALU_SLT, default: '0};
			OP_ANDI:  ctrl = '{regwrite: 1'b1, alusrc: 1'b1, alu_op: ALU_AND, default: '0};
			OP_ORI:   ctrl = '{regwrite: 1'b1, alusrc: 1'b1, alu_op: ALU_OR, default: '0};
			OP_LUI:   ctrl = '{regwrite: 1'b1, alusrc: 1'b1, alu_op: ALU_LUI, default: '0};
			OP_LW: begin
				ctrl.regwrite = 1'b1;
				ctrl.memread = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.alusrc = 1'b1;
			end
			OP_SW: begin
				ctrl.memwrite = 1'b1;
				ctrl.alusrc = 1'b1;
			end
			// Compare by subtraction, zero flag decides
			OP_BEQ: ctrl = '{branch: 1'b1, alu_op: ALU_SUB, default: '0};
			OP_BNE: ctrl = '{branch: 1'b1, branch_ne: 1'b1, alu_op: ALU_SUB, default: '0};
			OP_J:   ctrl.jump = 1'b1;
			OP_JAL: begin
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.regwrite = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

//--- verilog/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  reg_t     rs,
	input  reg_t     rt,
	input  reg_t     ex_dst,
	input  reg_t     mem_dst,
	input  reg_t     wb_dst,
	input  logic     ex_rw,
	input  logic     ex_load,
	input  logic     mem_rw,
	input  logic     wb_rw,
	output fwd_sel_e fwd_rs,
	output fwd_sel_e fwd_rt,
	output logic     stall
);

	// Youngest producer wins
	function automatic fwd_sel_e pick(input reg_t src, input reg_t e_dst, input logic e_rw,
			input reg_t m_dst, input logic m_rw, input reg_t w_dst, input logic w_rw);
		fwd_sel_e sel;
		sel = FWD_REG;
		if (src != '0) begin
			if (e_rw && e_dst == src)
				sel = FWD_EX;
			else if (m_rw && m_dst == src)
				sel = FWD_MEM;
			else if (w_rw && w_dst == src)
				sel = FWD_WB;
		end
		return sel;
	endfunction

	assign fwd_rs = pick(rs, ex_dst, ex_rw, mem_dst, mem_rw, wb_dst, wb_rw);
	assign fwd_rt = pick(rt, ex_dst, ex_rw, mem_dst, mem_rw, wb_dst, wb_rw);

	// Load data only exists one stage later
	assign stall = ex_load && ex_dst != '0 && (ex_dst == rs || ex_dst == rt);

endmodule

//--- verilog/regfile.sv
`timescale 1ns/1ps

module regfile (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  rs_addr,
	input  logic [4:0]  rt_addr,
	input  logic        we,
	input  logic [4:0]  wr_addr,
	input  logic [31:0] wr_data,
	output logic [31:0] rs_data,
	output logic [31:0] rt_data
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Bypass acts as write-first within the cycle
	assign rs_data = (rs_addr == '0) ? '0 : (we && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : (we && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu
	import isa_pkg::*;
(
	input  alu_op_e     op,
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [4:0]  shamt,
	output logic [31:0] result,
	output logic        zero
);

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
			// Shifts work on the rt operand
			ALU_SLL: result = b << shamt;
			ALU_SRL: result = b >> shamt;
			ALU_LUI: result = {b[15:0], 16'b0};
			default: result = '0;
		endcase
	end

	// Used by beq/bne
	assign zero = (result == '0);

endmodule

//--- verilog/cpu_core.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_core
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_data,
	output dbus_t       dbus,
	input  logic [31:0] dmem_rdata
);

	logic [31:0] pc, pc_plus4, pc_next;
	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;
	logic stall, ex_jump, br_taken;
	logic [31:0] ex_target;

	function automatic logic [31:0] fwd_mux(input fwd_sel_e sel, input logic [31:0] rf,
			input logic [31:0] ex, input logic [31:0] mem, input logic [31:0] wb);
		case (sel)
			FWD_EX:  return ex;
			FWD_MEM: return mem;
			FWD_WB:  return wb;
			default: return rf;
		endcase
	endfunction

	////////////////////////////////////////
	// Fetch
	////////////////////////////////////////

	assign pc_plus4 = pc + 32'd4;
	assign imem_addr = pc;

	// Branch in memory is older than a jump in execute
	assign pc_next = br_taken ? ex_mem.branch_target : ex_jump ? ex_target : pc_plus4;

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= `RESET_PC;
		else if (!stall || br_taken)
			pc <= pc_next;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || ex_jump || br_taken) begin
			if_id <= '0;
		end else if (!stall) begin
			if_id.pc_next <= pc_plus4;
			if_id.instr <= imem_data;
		end
	end

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////

	ctrl_t id_ctrl;
	fwd_sel_e fwd_rs, fwd_rt;
	logic [31:0] rf_rs, rf_rt, id_imm;
	logic [31:0] ex_result, mem_wdata;
	logic id_zext;
	reg_t ex_dst;

	decoder u_decoder (.instr(if_id.instr), .ctrl(id_ctrl));

	regfile u_regfile (
		.clk(clk), .rst_n(rst_n),
		.rs_addr(if_id.instr.r.rs), .rt_addr(if_id.instr.r.rt),
		.we(mem_wb.regwrite), .wr_addr(mem_wb.dst), .wr_data(mem_wb.wdata),
		.rs_data(rf_rs), .rt_data(rf_rt)
	);

	hazard_unit u_hazard (
		.rs(if_id.instr.r.rs), .rt(if_id.instr.r.rt),
		.ex_dst(ex_dst), .mem_dst(ex_mem.dst), .wb_dst(mem_wb.dst),
		.ex_rw(id_ex.ctrl.regwrite && !id_ex.ctrl.memread),
		.ex_load(id_ex.ctrl.memread),
		.mem_rw(ex_mem.ctrl.regwrite), .wb_rw(mem_wb.regwrite),
		.fwd_rs(fwd_rs), .fwd_rt(fwd_rt), .stall(stall)
	);

	// andi/ori take the immediate unsigned
	assign id_zext = (if_id.instr.i.op == OP_ANDI) || (if_id.instr.i.op == OP_ORI);
	assign id_imm = id_zext ? {16'b0, if_id.instr.i.imm}
			: {{16{if_id.instr.i.imm[15]}}, if_id.instr.i.imm};

	always_ff @(posedge clk) begin
		if (!rst_n || stall || ex_jump || br_taken) begin
			id_ex <= '0;
		end else begin
			id_ex.ctrl <= id_ctrl;
			id_ex.pc_next <= if_id.pc_next;
			id_ex.rs_data <= fwd_mux(fwd_rs, rf_rs, ex_result, mem_wdata, mem_wb.wdata);
			id_ex.rt_data <= fwd_mux(fwd_rt, rf_rt, ex_result, mem_wdata, mem_wb.wdata);
			id_ex.imm <= id_imm;
			id_ex.jtarget <= {if_id.pc_next[31:28], if_id.instr.j.target, 2'b00};
			id_ex.shamt <= if_id.instr.r.shamt;
			id_ex.rt <= if_id.instr.r.rt;
			id_ex.rd <= if_id.instr.r.rd;
		end
	end

	////////////////////////////////////////
	// Execute
	////////////////////////////////////////

	logic [31:0] alu_result;
	logic alu_zero;

	alu u_alu (
		.op(id_ex.ctrl.alu_op), .a(id_ex.rs_data),
		.b(id_ex.ctrl.alusrc ? id_ex.imm : id_ex.rt_data),
		.shamt(id_ex.shamt), .result(alu_result), .zero(alu_zero)
	);

	// jal writes the return address into r31
	assign ex_result = id_ex.ctrl.link ? id_ex.pc_next : alu_result;
	assign ex_dst = id_ex.ctrl.link ? 5'd31 : id_ex.ctrl.regdst ? id_ex.rd : id_ex.rt;
	assign ex_jump = id_ex.ctrl.jump;
	assign ex_target = id_ex.ctrl.jump_reg ? id_ex.rs_data : id_ex.jtarget;

	always_ff @(posedge clk) begin
		if (!rst_n || br_taken) begin
			ex_mem <= '0;
		end else begin
			ex_mem.ctrl <= id_ex.ctrl;
			ex_mem.branch_target <= id_ex.pc_next + {id_ex.imm[29:0], 2'b00};
			ex_mem.zero <= alu_zero;
			ex_mem.result <= ex_result;
			ex_mem.rt_data <= id_ex.rt_data;
			ex_mem.dst <= ex_dst;
		end
	end

	////////////////////////////////////////
	// Memory and write-back
	////////////////////////////////////////

	assign br_taken = ex_mem.ctrl.branch && (ex_mem.zero ^ ex_mem.ctrl.branch_ne);

	assign dbus.addr = ex_mem.result;
	assign dbus.wdata = ex_mem.rt_data;
	assign dbus.read = ex_mem.ctrl.memread;
	assign dbus.write = ex_mem.ctrl.memwrite;

	assign mem_wdata = ex_mem.ctrl.memtoreg ? dmem_rdata : ex_mem.result;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wb <= '0;
		end else begin
			mem_wb.regwrite <= ex_mem.ctrl.regwrite;
			mem_wb.wdata <= mem_wdata;
			mem_wb.dst <= ex_mem.dst;
		end
	end

endmodule

//--- verilog/mips_system.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module mips_system
	import pipe_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        prog_we,
	input  logic [7:0]  prog_addr,
	input  logic [31:0] prog_data,
	output logic        io_valid,
	output logic [7:0]  io_addr,
	output logic [31:0] io_data
);

	logic [31:0] imem_addr, imem_data, dmem_rdata;
	dbus_t dbus;
	logic io_sel;

	logic [31:0] imem [`IMEM_WORDS];
	logic [31:0] dmem [`DMEM_WORDS];

	cpu_core u_core (
		.clk(clk),
		.rst_n(rst_n),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dbus(dbus),
		.dmem_rdata(dmem_rdata)
	);

	// Program load port
	always_ff @(posedge clk) begin
		if (prog_we)
			imem[prog_addr] <= prog_data;
	end

	assign imem_data = imem[imem_addr[`IMEM_AW+1:2]];

	// I/O when the top address bits are all ones
	assign io_sel = &dbus.addr[31 -: `IO_TAG_BITS];

	always_ff @(posedge clk) begin
		if (dbus.write && !io_sel)
			dmem[dbus.addr[`DMEM_AW+1:2]] <= dbus.wdata;
	end

	// I/O space reads back as zero
	assign dmem_rdata = (dbus.read && !io_sel) ? dmem[dbus.addr[`DMEM_AW+1:2]] : '0;

	always_ff @(posedge clk) begin
		if (!rst_n)
			io_valid <= 1'b0;
		else
			io_valid <= dbus.write && io_sel;
	end

	always_ff @(posedge clk) begin
		if (dbus.write && io_sel) begin
			io_addr <= dbus.addr[7:0];
			io_data <= dbus.wdata;
		end
	end

endmodule

//--- testbench/mips_system_asserts.sv
`timescale 1ns/1ps

module mips_system_asserts
	import pipe_pkg::*;
(
	input logic    clk,
	input logic    rst_n,
	input logic    stall,
	input logic    ex_jump,
	input logic    br_taken,
	input ex_mem_t ex_mem,
	input dbus_t   dbus
);

	int fail_count = 0;

	// Write in the memory stage that changes memory or a real register
	logic mem_writes;

	assign mem_writes = ex_mem.ctrl.memwrite || (ex_mem.ctrl.regwrite && ex_mem.dst != '0);

	// Load-use costs exactly one bubble
	stall_single: assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall)
		else begin
			$error("stall held for two consecutive cycles");
			fail_count++;
		end

	// Stall bubble reaches the memory stage two cycles later
	stall_bubble: assert property (@(posedge clk) disable iff (!rst_n)
			$past(stall, 2) |-> !mem_writes)
		else begin
			$error("bubble from a stall reached memory with a write enabled");
			fail_count++;
		end

	// Wrong-path slots behind a jump or taken branch arrive as bubbles
	flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
			($past(br_taken) || $past(ex_jump || br_taken, 2)
			|| $past(ex_jump || br_taken, 3)) |-> !mem_writes)
		else begin
			$error("wrong-path instruction reached memory with a write enabled");
			fail_count++;
		end

	dbus_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
			!(dbus.read && dbus.write))
		else begin
			$error("data bus read and write asserted together");
			fail_count++;
		end

endmodule

bind cpu_core mips_system_asserts u_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.stall(stall),
	.ex_jump(ex_jump),
	.br_taken(br_taken),
	.ex_mem(ex_mem),
	.dbus(dbus)
);

//--- testbench/tb_mips_system.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_mips_system
	import isa_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 1;
	localparam int RESET_CYCLES = 2;
	localparam int NUM_PROGS = 5;
	localparam int PROG_LEN = 40;
	localparam int LOAD_WORDS = 4;
	localparam int QUIET_CYCLES = 20;
	localparam int STEP_LIMIT = 1000;
	// Per program: run budget, load through the port, reset and quiet window
	localparam int WATCHDOG_NS = NUM_PROGS * CLK_PERIOD
			* (PROG_LEN * 8 + `IMEM_WORDS + RESET_CYCLES + QUIET_CYCLES);

	logic        clk;
	logic        rst_n;
	logic        prog_we;
	logic [7:0]  prog_addr;
	logic [31:0] prog_data;
	logic        io_valid;
	logic [7:0]  io_addr;
	logic [31:0] io_data;
	logic        rst_at_edge;

	logic [31:0] prog [`IMEM_WORDS];
	int          plen;
	logic [31:0] lcg_state;
	logic [7:0]  exp_addr [$];
	logic [31:0] exp_data [$];
	int          seen;
	int          checked;
	int          errors;

	mips_system uut (
		.clk(clk),
		.rst_n(rst_n),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.io_valid(io_valid),
		.io_addr(io_addr),
		.io_data(io_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////
	// Random numbers and encoding
	////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = next_rand();
		return int'(r[30:16]) % n;
	endfunction

	// Small register set keeps dependency chains dense
	function automatic reg_t rand_reg();
		return reg_t'(rand_below(8));
	endfunction

	function automatic logic [15:0] rand_imm();
		logic [31:0] r;
		r = next_rand();
		return r[23:8];
	endfunction

	function automatic logic [31:0] r_word(input funct_e f, input reg_t rs, input reg_t rt,
			input reg_t rd, input logic [4:0] sh);
		instr_u w;
		w.r.op = OP_RTYPE;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.shamt = sh;
		w.r.funct = f;
		return w;
	endfunction

	function automatic logic [31:0] i_word(input opcode_e op, input reg_t rs, input reg_t rt,
			input logic [15:0] imm);
		instr_u w;
		w.i.op = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm = imm;
		return w;
	endfunction

	function automatic logic [31:0] j_word(input opcode_e op, input logic [25:0] target);
		instr_u w;
		w.j.op = op;
		w.j.target = target;
		return w;
	endfunction

	// Base r0 with a negative offset lands in the I/O range
	function automatic logic [31:0] io_store(input reg_t rt);
		logic [7:0] lo;
		lo = 8'(rand_below(64) * 4);
		return i_word(OP_SW, 5'd0, rt, {8'hFF, lo});
	endfunction

	function automatic logic [15:0] mem_offset();
		return 16'(rand_below(LOAD_WORDS) * 4);
	endfunction

	function automatic void emit(input logic [31:0] w);
		prog[plen] = w;
		plen++;
	endfunction

	////////////////////////////////////////
	// Program generator
	////////////////////////////////////////

	task automatic emit_alu_r();
		funct_e f;
		reg_t rs;
		reg_t rt;
		reg_t rd;
		logic [4:0] sh;
		case (rand_below(8))
			0: f = F_ADDU;
			1: f = F_SUBU;
			2: f = F_AND;
			3: f = F_OR;
			4: f = F_XOR;
			5: f = F_SLT;
			6: f = F_SLL;
			default: f = F_SRL;
		endcase
		rs = rand_reg();
		rt = rand_reg();
		rd = rand_reg();
		sh = 5'd0;
		if (f == F_SLL || f == F_SRL) begin
			rs = 5'd0;
			sh = 5'(rand_below(32));
		end
		emit(r_word(f, rs, rt, rd, sh));
	endtask

	task automatic emit_alu_i();
		opcode_e op;
		reg_t rs;
		reg_t rt;
		logic [15:0] imm;
		case (rand_below(5))
			0: op = OP_ADDIU;
			1: op = OP_SLTI;
			2: op = OP_ANDI;
			3: op = OP_ORI;
			default: op = OP_LUI;
		endcase
		rs = (op == OP_LUI) ? 5'd0 : rand_reg();
		rt = rand_reg();
		imm = rand_imm();
		emit(i_word(op, rs, rt, imm));
	endtask

	// Forward branch over a block, so targets stay on block edges
	task automatic emit_branch();
		int skip;
		opcode_e op;
		reg_t rs;
		reg_t rt;
		skip = 1 + rand_below(3);
		op = (rand_below(2) == 0) ? OP_BEQ : OP_BNE;
		rs = rand_reg();
		rt = rand_reg();
		emit(i_word(op, rs, rt, 16'(skip)));
		// First skipped slot stores, so a wrong-path write would show
		emit(io_store(rand_reg()));
		for (int k = 1; k < skip; k++)
			emit_alu_r();
	endtask

	// jal to a two-instruction subroutine, link value stored out, then jump past it
	task automatic emit_call();
		int base;
		base = plen;
		emit(j_word(OP_JAL, 26'(base + 3)));
		emit(i_word(OP_SW, 5'd0, 5'd31, 16'hFFF0));
		emit(j_word(OP_J, 26'(base + 5)));
		emit_alu_r();
		emit(r_word(F_JR, 5'd31, 5'd0, 5'd0, 5'd0));
	endtask

	task automatic gen_program();
		int base;
		reg_t rt;
		reg_t rs;
		logic [15:0] imm;
		plen = 0;
		// Known data words for the loads, r1..r4 get values too
		for (int k = 0; k < LOAD_WORDS; k++) begin
			emit(i_word(OP_ADDIU, 5'd0, reg_t'(k + 1), rand_imm()));
			emit(i_word(OP_SW, 5'd0, reg_t'(k + 1), 16'(k * 4)));
		end
		while (plen < PROG_LEN) begin
			case (rand_below(11))
				0, 1, 2: emit_alu_r();
				3, 4: emit_alu_i();
				5: begin
					rt = rand_reg();
					emit(i_word(OP_LW, 5'd0, rt, mem_offset()));
					// Consumer right behind the load
					if (rand_below(2) == 0) begin
						rs = rand_reg();
						emit(r_word(F_ADDU, rt, rs, rand_reg(), 5'd0));
					end else begin
						emit(io_store(rt));
					end
				end
				6: emit(i_word(OP_SW, 5'd0, rand_reg(), mem_offset()));
				7: emit(io_store(rand_reg()));
				8: emit_branch();
				9: emit_call();
				default: begin
					rs = rand_reg();
					imm = rand_imm();
					emit(i_word(OP_ADDIU, rs, 5'd0, imm));
					emit(io_store(5'd0));
				end
			endcase
		end
		emit(i_word(OP_SW, 5'd0, rand_reg(), 16'hFFFC));
		base = plen;
		emit(j_word(OP_J, 26'(base)));
	endtask

	////////////////////////////////////////
	// Instruction-set model
	////////////////////////////////////////

	task automatic run_model();
		logic [31:0] regs_m [32];
		logic [31:0] mem_m [`DMEM_WORDS];
		instr_u ins;
		logic [31:0] pc, npc, a, b, sext, zext, addr, jt;
		int steps;
		exp_addr.delete();
		exp_data.delete();
		for (int i = 0; i < 32; i++)
			regs_m[i] = 32'h0;
		for (int i = 0; i < `DMEM_WORDS; i++)
			mem_m[i] = 32'h0;
		pc = `RESET_PC;
		steps = 0;
		while (steps < STEP_LIMIT) begin
			ins = prog[pc[`IMEM_AW+1:2]];
			a = regs_m[ins.r.rs];
			b = regs_m[ins.r.rt];
			sext = {{16{ins.i.imm[15]}}, ins.i.imm};
			zext = {16'h0, ins.i.imm};
			npc = pc + 32'd4;
			jt = {npc[31:28], ins.j.target, 2'b00};
			addr = a + sext;
			// Self-jump ends the program
			if (ins.j.op == OP_J && jt == pc)
				break;
			case (ins.r.op)
				OP_RTYPE: begin
					case (ins.r.funct)
						F_ADDU: regs_m[ins.r.rd] = a + b;
						F_SUBU: regs_m[ins.r.rd] = a - b;
						F_AND:  regs_m[ins.r.rd] = a & b;
						F_OR:   regs_m[ins.r.rd] = a | b;
						F_XOR:  regs_m[ins.r.rd] = a ^ b;
						F_SLT:  regs_m[ins.r.rd] = {31'h0, $signed(a) < $signed(b)};
						F_SLL:  regs_m[ins.r.rd] = b << ins.r.shamt;
						F_SRL:  regs_m[ins.r.rd] = b >> ins.r.shamt;
						F_JR:   npc = a;
						default: ;
					endcase
				end
				OP_ADDIU: regs_m[ins.i.rt] = a + sext;
				OP_SLTI:  regs_m[ins.i.rt] = {31'h0, $signed(a) < $signed(sext)};
				OP_ANDI:  regs_m[ins.i.rt] = a & zext;
				OP_ORI:   regs_m[ins.i.rt] = a | zext;
				OP_LUI:   regs_m[ins.i.rt] = {ins.i.imm, 16'h0};
				OP_LW:    regs_m[ins.i.rt] = mem_m[addr[`DMEM_AW+1:2]];
				OP_SW: begin
					if (&addr[31 -: `IO_TAG_BITS]) begin
						exp_addr.push_back(addr[7:0]);
						exp_data.push_back(b);
					end else begin
						mem_m[addr[`DMEM_AW+1:2]] = b;
					end
				end
				OP_BEQ: if (a == b) npc = npc + (sext << 2);
				OP_BNE: if (a != b) npc = npc + (sext << 2);
				OP_J:   npc = jt;
				OP_JAL: begin
					regs_m[31] = npc;
					npc = jt;
				end
				default: ;
			endcase
			regs_m[0] = 32'h0;
			pc = npc;
			steps++;
		end
		assert (steps < STEP_LIMIT) else begin
			$display("Model did not reach the closing self-jump within %0d steps", STEP_LIMIT);
			errors++;
		end
	endtask

	////////////////////////////////////////
	// Loader, monitor and sequence
	////////////////////////////////////////

	// Whole memory is written so no old program survives
	task automatic load_and_reset();
		@(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b0;
		for (int i = 0; i < `IMEM_WORDS; i++) begin
			prog_we = 1'b1;
			prog_addr = 8'(i);
			prog_data = (i < plen) ? prog[i] : 32'h0;
			@(posedge clk);
			#DRIVE_DELAY;
		end
		prog_we = 1'b0;
		seen = 0;
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		rst_n = 1'b1;
	endtask

	task automatic check_io_write();
		logic [7:0] want_addr;
		logic [31:0] want_data;
		assert (seen < exp_data.size()) else begin
			$display("Unexpected I/O write to %h with data %h", io_addr, io_data);
			errors++;
		end
		if (seen < exp_data.size()) begin
			want_addr = exp_addr[seen];
			want_data = exp_data[seen];
			assert (io_addr === want_addr) else begin
				$display("FAILED io_addr: got %h, expected %h", io_addr, want_addr);
				errors++;
			end
			assert (io_data === want_data) else begin
				$display("FAILED io_data: got %h, expected %h", io_data, want_data);
				errors++;
			end
		end
		seen++;
		checked++;
	endtask

	// Reset level the DUT saw at the last rising edge
	always @(posedge clk)
		rst_at_edge <= rst_n;

	// Outputs settle well before the falling edge
	always @(negedge clk) begin
		if (rst_at_edge === 1'b0) begin
			assert (io_valid === 1'b0) else begin
				$display("io_valid was not low while reset was asserted");
				errors++;
			end
		end else if (rst_n === 1'b1 && io_valid === 1'b1) begin
			check_io_write();
		end
	end

	initial begin
		errors = 0;
		checked = 0;
		seen = 0;
		plen = 0;
		lcg_state = 32'd29;
		rst_n = 1'b0;
		prog_we = 1'b0;
		prog_addr = 8'h00;
		prog_data = 32'h0;
		for (int p = 0; p < NUM_PROGS; p++) begin
			gen_program();
			run_model();
			load_and_reset();
			while (seen < exp_data.size())
				@(negedge clk);
			// Nothing more may come out of the self-jump loop
			repeat (QUIET_CYCLES) @(negedge clk);
			$display("Program %0d: %0d instructions, %0d I/O writes", p, plen, exp_data.size());
		end
		$display("Programs: %0d, I/O writes: %0d, errors: %0d, assertion failures: %0d",
				NUM_PROGS, checked, errors, uut.u_core.u_asserts.fail_count);
		if (errors == 0 && uut.u_core.u_asserts.fail_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- mips_system.f
+incdir+include
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/decoder.sv
verilog/hazard_unit.sv
verilog/regfile.sv
verilog/alu.sv
verilog/cpu_core.sv
verilog/mips_system.sv
testbench/mips_system_asserts.sv
testbench/tb_mips_system.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_system
FILELIST  ?= mips_system.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
